// File: powerIsaPkg.sv
package powerIsaPkg;

	localparam int regWidth = 5;
	localparam int xopWidth = 10;
	localparam int instrWidth = 32;
	localparam int primaryWidth = instrWidth - 3 * regWidth - xopWidth - 1;

	////////////////////
	// X-form word, POWER bit 0 is the msb
	////////////////////
	typedef struct packed {
		logic [primaryWidth-1:0] primaryOp;
		logic [regWidth-1:0] rt;
		logic [regWidth-1:0] ra;
		logic [regWidth-1:0] rb;
		logic [xopWidth-1:0] xOpcode;
		logic recordBit;
	} instrWord_t;

	typedef enum logic [primaryWidth-1:0] {
		primaryX31 = 6'd31,
		primaryFp59 = 6'd59,
		primaryFp63 = 6'd63
	} primaryOp_e;

	////////////////////
	// load/store under 31
	////////////////////
	typedef enum logic [xopWidth-1:0] {
		xLbzx = 10'd87, xLbzux = 10'd119,
		xLhzx = 10'd279, xLhzux = 10'd311,
		xLhax = 10'd343, xLhaux = 10'd375,
		xLwzx = 10'd23, xLwzux = 10'd55,
		xLwax = 10'd341, xLwaux = 10'd373,
		xLdx = 10'd21, xLdux = 10'd53,
		xStbx = 10'd215, xStbux = 10'd247,
		xSthx = 10'd407, xSthux = 10'd439,
		xStwx = 10'd151, xStwux = 10'd183,
		xStdx = 10'd149, xStdux = 10'd181,
		xLhbrx = 10'd790, xLwbrx = 10'd534, xLdbrx = 10'd532, // byte reverse
		xSthbrx = 10'd918, xStwbrx = 10'd662, xStdbrx = 10'd660,
		xLswi = 10'd597, xLswx = 10'd533, // string forms
		xStswi = 10'd725, xStswx = 10'd661,
		xLfsx = 10'd535, xLfsux = 10'd567, // float loads
		xLfdx = 10'd599, xLfdux = 10'd631,
		xLfiwzx = 10'd887, xLfiwax = 10'd855, xLfdpx = 10'd791,
		xStfsx = 10'd663, xStfsux = 10'd695, // float stores
		xStfdx = 10'd727, xStfdux = 10'd759,
		xStfiwx = 10'd983, xStfdpx = 10'd919
	} ldStXop_e;

	////////////////////
	// fixed point and trap under 31
	////////////////////
	typedef enum logic [xopWidth-1:0] {
		xCmp = 10'd0, xCmpl = 10'd32, xCmprb = 10'd192, xCmpeqb = 10'd224,
		xTw = 10'd4, xTd = 10'd68,
		xAnd = 10'd28, xOr = 10'd444, xXor = 10'd316, xNand = 10'd476,
		xNor = 10'd124, xEqv = 10'd284, xAndc = 10'd60, xOrc = 10'd412,
		xExtsb = 10'd954, xExtsh = 10'd922, xExtsw = 10'd986,
		xCntlzw = 10'd26, xCnttzw = 10'd538, xCntlzd = 10'd58, xCnttzd = 10'd570,
		xCmpb = 10'd508, xBpermd = 10'd252,
		xPopcntb = 10'd122, xPopcntw = 10'd378, xPopcntd = 10'd506,
		xPrtyd = 10'd186, xPrtyw = 10'd154,
		xSlw = 10'd24, xSrw = 10'd536, xSrawi = 10'd824, xSraw = 10'd792,
		xSld = 10'd27, xSrd = 10'd539, xSrad = 10'd794,
		xCdtbcd = 10'd282, xCbcdtd = 10'd314,
		xMfvsrd = 10'd51, xMfvsrld = 10'd307, xMfvsrwz = 10'd115,
		xMtvsrd = 10'd179, xMtvsrwa = 10'd211, xMtvsrwz = 10'd243,
		xMtvsrdd = 10'd435, xMtvsrws = 10'd403,
		xModsw = 10'd779, xModuw = 10'd267, xModsd = 10'd777, xModud = 10'd265,
		xDarn = 10'd755, xMcrxrx = 10'd576, xSetb = 10'd128
	} fixedXop_e;

	////////////////////
	// floating point under 63, xFcfidu also valid under 59
	////////////////////
	typedef enum logic [xopWidth-1:0] {
		xFmr = 10'd72, xFneg = 10'd40, xFabs = 10'd264, xFnabs = 10'd136,
		xFcpsgn = 10'd8, xFmrgew = 10'd966, xFmrgow = 10'd838,
		xFtdiv = 10'd128, xFtsqrt = 10'd160, xFrsp = 10'd12,
		xFctid = 10'd814, xFctidz = 10'd815, xFctidu = 10'd942, xFctiduz = 10'd943,
		xFctiw = 10'd14, xFctiwz = 10'd15, xFctiwu = 10'd142, xFctiwuz = 10'd143,
		xFcfid = 10'd846, xFcfidu = 10'd974,
		xFrin = 10'd392, xFriz = 10'd424, xFrip = 10'd456, xFrim = 10'd488,
		xFcmpu = 10'd0, xFcmpo = 10'd32,
		xMcrfs = 10'd64, xMtfsfi = 10'd134, xMtfsb0 = 10'd70, xMtfsb1 = 10'd38
	} floatXop_e;

endpackage

// File: dispatchPkg.sv
package dispatchPkg;

	// target unit for dispatch
	typedef enum logic [2:0] {
		fixedUnit,
		floatUnit,
		loadStoreUnit,
		branchUnit,
		trapUnit
	} unit_e;

	// one classifier's verdict
	typedef struct packed {
		logic hit;
		unit_e unit;
		logic raZeroIsLiteral; // ra == 0 reads as literal zero
	} classHit_t;

	typedef struct packed {
		logic [powerIsaPkg::xopWidth-1:0] xOpcode;
		logic [powerIsaPkg::regWidth-1:0] rt;
		logic [powerIsaPkg::regWidth-1:0] ra;
		logic [powerIsaPkg::regWidth-1:0] rb;
		logic recordBit;
		unit_e unit;
		logic raZeroIsLiteral;
	} decodedOp_t;

endpackage

// File: loadStoreClassifier.sv
`timescale 1ns/1ns

module loadStoreClassifier (
	input powerIsaPkg::instrWord_t instruction_i,
	output dispatchPkg::classHit_t hit_o
);

	import powerIsaPkg::*;
	import dispatchPkg::*;

	always_comb begin
		hit_o = '{hit: 1'b0, unit: loadStoreUnit, raZeroIsLiteral: 1'b0};
		if (instruction_i.primaryOp == primaryX31) begin
			case (instruction_i.xOpcode)
				// plain indexed forms, ra of zero means zero
				xLbzx, xLhzx, xLhax, xLwzx, xLwax, xLdx,
				xStbx, xSthx, xStwx, xStdx,
				xLhbrx, xLwbrx, xLdbrx, xSthbrx, xStwbrx, xStdbrx,
				xLswi, xLswx, xStswi, xStswx,
				xLfsx, xLfdx, xLfiwzx, xLfiwax, xLfdpx,
				xStfsx, xStfdx, xStfiwx, xStfdpx: begin
					hit_o.hit = 1'b1;
					hit_o.raZeroIsLiteral = 1'b1;
				end
				// update forms write ra back
				xLbzux, xLhzux, xLhaux, xLwzux, xLwaux, xLdux,
				xStbux, xSthux, xStwux, xStdux,
				xLfsux, xLfdux, xStfsux, xStfdux: begin
					hit_o.hit = 1'b1;
				end
				default: begin
					hit_o.hit = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: fixedPointClassifier.sv
`timescale 1ns/1ns

module fixedPointClassifier (
	input powerIsaPkg::instrWord_t instruction_i,
	output dispatchPkg::classHit_t hit_o
);

	import powerIsaPkg::*;
	import dispatchPkg::*;

	// ra is always a real register here
	always_comb begin
		hit_o = '{hit: 1'b0, unit: fixedUnit, raZeroIsLiteral: 1'b0};
		if (instruction_i.primaryOp == primaryX31) begin
			case (instruction_i.xOpcode)
				xTw, xTd: begin
					hit_o.hit = 1'b1;
					hit_o.unit = trapUnit;
				end
				xCmp, xCmpl, xCmprb, xCmpeqb, // compares
				xAnd, xOr, xXor, xNand, xNor, xEqv, xAndc, xOrc,
				xExtsb, xExtsh, xExtsw,
				xCntlzw, xCnttzw, xCntlzd, xCnttzd,
				xCmpb, xBpermd,
				xPopcntb, xPopcntw, xPopcntd,
				xPrtyd, xPrtyw,
				xSlw, xSrw, xSrawi, xSraw, xSld, xSrd, xSrad, // shifts
				xCdtbcd, xCbcdtd,
				xMfvsrd, xMfvsrld, xMfvsrwz, // vsr moves
				xMtvsrd, xMtvsrwa, xMtvsrwz, xMtvsrdd, xMtvsrws,
				xModsw, xModuw, xModsd, xModud,
				xDarn, xMcrxrx, xSetb: begin
					hit_o.hit = 1'b1;
				end
				default: begin
					hit_o.hit = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: floatClassifier.sv
`timescale 1ns/1ns

module floatClassifier (
	input powerIsaPkg::instrWord_t instruction_i,
	output dispatchPkg::classHit_t hit_o
);

	import powerIsaPkg::*;
	import dispatchPkg::*;

	always_comb begin
		hit_o = '{hit: 1'b0, unit: floatUnit, raZeroIsLiteral: 1'b0};
		if (instruction_i.primaryOp == primaryFp63) begin
			case (instruction_i.xOpcode)
				xFmr, xFneg, xFabs, xFnabs, xFcpsgn, xFmrgew, xFmrgow,
				xFtdiv, xFtsqrt, xFrsp,
				xFctid, xFctidz, xFctidu, xFctiduz, // to integer
				xFctiw, xFctiwz, xFctiwu, xFctiwuz,
				xFcfid, xFcfidu, // from integer
				xFrin, xFriz, xFrip, xFrim,
				xFcmpu, xFcmpo,
				xMcrfs, xMtfsfi, xMtfsb0, xMtfsb1: begin
					hit_o.hit = 1'b1;
				end
				default: begin
					hit_o.hit = 1'b0;
				end
			endcase
		end else if (instruction_i.primaryOp == primaryFp59) begin
			// single precision convert is the only 59 entry
			hit_o.hit = (instruction_i.xOpcode == xFcfidu);
		end
	end

endmodule

// File: decodeIssueStage.sv
`timescale 1ns/1ns

module decodeIssueStage (
	input logic clock_i,
	input logic reset_i,
	input logic enable_i,
	input powerIsaPkg::instrWord_t instruction_i,
	input dispatchPkg::classHit_t ldStHit_i,
	input dispatchPkg::classHit_t fixedHit_i,
	input dispatchPkg::classHit_t floatHit_i,
	output dispatchPkg::decodedOp_t decoded_o,
	output logic valid_o
);

	import dispatchPkg::*;

	classHit_t selHit;
	decodedOp_t nextOp;
	logic issue;

	// classifier tables are disjoint
	always_comb begin
		selHit = '{hit: 1'b0, unit: fixedUnit, raZeroIsLiteral: 1'b0};
		if (ldStHit_i.hit)
			selHit = ldStHit_i;
		else if (fixedHit_i.hit)
			selHit = fixedHit_i;
		else if (floatHit_i.hit)
			selHit = floatHit_i;
	end

	always_comb begin
		nextOp.xOpcode = instruction_i.xOpcode;
		nextOp.rt = instruction_i.rt;
		nextOp.ra = instruction_i.ra;
		nextOp.rb = instruction_i.rb;
		nextOp.recordBit = instruction_i.recordBit; // bit 31 for every primary
		nextOp.unit = selHit.unit;
		nextOp.raZeroIsLiteral = selHit.raZeroIsLiteral;
	end

	assign issue = enable_i & selHit.hit;

	always_ff @(posedge clock_i) begin
		if (reset_i)
			valid_o <= 1'b0;
		else
			valid_o <= issue;
	end

	always_ff @(posedge clock_i) begin
		if (issue)
			decoded_o <= nextOp; // holds otherwise
	end

	////////////////////
	// checks
	////////////////////
	oneClassifierHit: assert property (@(posedge clock_i) disable iff (reset_i)
		$onehot0({ldStHit_i.hit, fixedHit_i.hit, floatHit_i.hit}));

	validLowAfterReset: assert property (@(posedge clock_i)
		reset_i |=> !valid_o);

endmodule

// File: xFormDecoder.sv
`timescale 1ns/1ns

module xFormDecoder (
	input logic clock_i,
	input logic reset_i,
	input logic enable_i,
	input powerIsaPkg::instrWord_t instruction_i,
	output dispatchPkg::decodedOp_t decoded_o,
	output logic valid_o
);

	import dispatchPkg::*;

	classHit_t ldStHit;
	classHit_t fixedHit;
	classHit_t floatHit;

	loadStoreClassifier u_ldSt (
		.instruction_i(instruction_i),
		.hit_o(ldStHit)
	);

	fixedPointClassifier u_fixed (
		.instruction_i(instruction_i),
		.hit_o(fixedHit)
	);

	floatClassifier u_float (
		.instruction_i(instruction_i),
		.hit_o(floatHit)
	);

	decodeIssueStage u_issue (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.ldStHit_i(ldStHit),
		.fixedHit_i(fixedHit),
		.floatHit_i(floatHit),
		.decoded_o(decoded_o),
		.valid_o(valid_o)
	);

endmodule

// File: xFormCases.svh
`ifndef X_FORM_CASES_SVH
`define X_FORM_CASES_SVH

// register fields and record bit come from the testbench
typedef struct packed {
	logic [powerIsaPkg::primaryWidth-1:0] primaryOp;
	logic [powerIsaPkg::xopWidth-1:0] xOpcode;
	logic enable;
	logic expValid;
	dispatchPkg::unit_e expUnit;
	logic expRaZero;
} xFormCase_t;

localparam int numCases = 25;

localparam xFormCase_t caseTable [numCases] = '{
	// load/store, plain indexed
	'{6'd31, 10'd87, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd31, 10'd21, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd31, 10'd215, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd31, 10'd535, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd31, 10'd343, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd31, 10'd983, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b1},
	// update forms
	'{6'd31, 10'd119, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b0},
	'{6'd31, 10'd53, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b0},
	'{6'd31, 10'd181, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b0},
	'{6'd31, 10'd759, 1'b1, 1'b1, dispatchPkg::loadStoreUnit, 1'b0},
	// fixed point and trap
	'{6'd31, 10'd28, 1'b1, 1'b1, dispatchPkg::fixedUnit, 1'b0},
	'{6'd31, 10'd0, 1'b1, 1'b1, dispatchPkg::fixedUnit, 1'b0},
	'{6'd31, 10'd536, 1'b1, 1'b1, dispatchPkg::fixedUnit, 1'b0},
	'{6'd31, 10'd444, 1'b1, 1'b1, dispatchPkg::fixedUnit, 1'b0},
	'{6'd31, 10'd4, 1'b1, 1'b1, dispatchPkg::trapUnit, 1'b0},
	'{6'd31, 10'd68, 1'b1, 1'b1, dispatchPkg::trapUnit, 1'b0},
	// floating point
	'{6'd63, 10'd72, 1'b1, 1'b1, dispatchPkg::floatUnit, 1'b0},
	'{6'd63, 10'd846, 1'b1, 1'b1, dispatchPkg::floatUnit, 1'b0},
	'{6'd63, 10'd38, 1'b1, 1'b1, dispatchPkg::floatUnit, 1'b0},
	'{6'd59, 10'd974, 1'b1, 1'b1, dispatchPkg::floatUnit, 1'b0},
	// no hit, valid drops
	'{6'd59, 10'd72, 1'b1, 1'b0, dispatchPkg::fixedUnit, 1'b0},
	'{6'd31, 10'd1, 1'b1, 1'b0, dispatchPkg::fixedUnit, 1'b0},
	'{6'd14, 10'd87, 1'b1, 1'b0, dispatchPkg::fixedUnit, 1'b0},
	// strobe low
	'{6'd31, 10'd87, 1'b0, 1'b0, dispatchPkg::loadStoreUnit, 1'b1},
	'{6'd63, 10'd0, 1'b1, 1'b1, dispatchPkg::floatUnit, 1'b0}
};

`endif

// File: tb_xFormDecoder.sv
`timescale 1ns/1ns

module tb_xFormDecoder;

	import powerIsaPkg::*;
	import dispatchPkg::*;

	`include "xFormCases.svh"

	localparam int timeoutCycles = 2 * numCases + 20;

	logic clock_i;
	logic reset_i;
	logic enable_i;
	instrWord_t instruction_i;
	decodedOp_t decoded_o;
	logic valid_o;

	instrWord_t sentWord; // last word driven
	decodedOp_t lastRecord;
	logic haveRecord;
	int cycleCount = 0;

	xFormDecoder u_dut (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.decoded_o(decoded_o),
		.valid_o(valid_o)
	);

	always #5 clock_i = ~clock_i;

	always @(posedge clock_i) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: table not finished after %0d cycles", cycleCount);
			$display("TB FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic reportMismatch(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "run stopped at first mismatch");
	endtask

	// random register fields and record bit
	task automatic driveCase(input int idx);
		instrWord_t word;
		word.primaryOp = caseTable[idx].primaryOp;
		word.rt = 5'($urandom);
		word.ra = 5'($urandom);
		word.rb = 5'($urandom);
		word.xOpcode = caseTable[idx].xOpcode;
		word.recordBit = 1'($urandom);
		instruction_i = word;
		enable_i = caseTable[idx].enable;
		sentWord = word;
	endtask

	task automatic checkCase(input int idx);
		decodedOp_t expRec;
		expRec.xOpcode = sentWord.xOpcode;
		expRec.rt = sentWord.rt;
		expRec.ra = sentWord.ra;
		expRec.rb = sentWord.rb;
		expRec.recordBit = sentWord.recordBit;
		expRec.unit = caseTable[idx].expUnit;
		expRec.raZeroIsLiteral = caseTable[idx].expRaZero;
		assert (valid_o === caseTable[idx].expValid) else
			reportMismatch($sformatf("case %0d: valid %b, expected %b",
				idx, valid_o, caseTable[idx].expValid));
		if (caseTable[idx].expValid) begin
			assert (decoded_o === expRec) else
				reportMismatch($sformatf("case %0d: record %h, expected %h",
					idx, decoded_o, expRec));
			lastRecord = expRec;
			haveRecord = 1'b1;
		end else if (haveRecord) begin
			// record must hold when nothing issues
			assert (decoded_o === lastRecord) else
				reportMismatch($sformatf("case %0d: record %h did not hold %h",
					idx, decoded_o, lastRecord));
		end
	endtask

	initial begin
		clock_i = 1'b0;
		reset_i = 1'b1;
		enable_i = 1'b0;
		instruction_i = '0;
		sentWord = '0;
		lastRecord = '0;
		haveRecord = 1'b0;
		void'($urandom(32'hb6f8ba4d));

		repeat (4) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		assert (valid_o === 1'b0) else
			reportMismatch($sformatf("valid %b after reset, expected 0", valid_o));

		//////////////////////
		// one entry per cycle, checked one edge later
		//////////////////////
		for (int i = 0; i < numCases; i++) begin
			driveCase(i);
			@(posedge clock_i);
			#1;
			checkCase(i);
		end
		enable_i = 1'b0;

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+.
powerIsaPkg.sv
dispatchPkg.sv
loadStoreClassifier.sv
fixedPointClassifier.sv
floatClassifier.sv
decodeIssueStage.sv
xFormDecoder.sv
tb_xFormDecoder.sv
